// File: files.f
hw/cu_pkg.sv
hw/instr_decoder.sv
hw/cu_sequencer.sv
hw/control_word_gen.sv
hw/control_unit.sv
+incdir+tests
tests/tb_control_unit.sv

// File: hw/control_unit.sv
`default_nettype none

module control_unit (
    input  wire                         clk,
    input  wire                         reset,
    input  wire cu_pkg::instr_word_t    instruction,
    input  wire                         zero_flag,
    input  wire                         overflow,
    input  wire                         div_zero,
    output wire cu_pkg::instr_fields_t  fields,
    output wire cu_pkg::ctrl_word_t     ctrl,
    output wire cu_pkg::cu_state_t      current_state
);
    import cu_pkg::*;

    instr_class_t iclass;
    step_t        step;

    instr_decoder u_decoder (
        .instruction (instruction),
        .fields      (fields),
        .iclass      (iclass)
    );

    // Only block with registers
    cu_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .iclass   (iclass),
        .overflow (overflow),
        .div_zero (div_zero),
        .state    (current_state),
        .step     (step)
    );

    control_word_gen u_ctrl_gen (
        .state     (current_state),
        .step      (step),
        .zero_flag (zero_flag),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// File: hw/control_word_gen.sv
`default_nettype none

module control_word_gen (
    input  wire cu_pkg::cu_state_t state,
    input  wire cu_pkg::step_t     step,
    input  wire                    zero_flag,
    output cu_pkg::ctrl_word_t     ctrl
);
    import cu_pkg::*;

    always_comb
    begin
        ctrl = '0; // Reset and decode leave everything idle
        case (state)
            ST_FETCH:
            begin
                ctrl.mem_read  = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_INC;
            end
            ST_ADD, ST_AND, ST_SUB, ST_SLT:
            begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_ALU;
                case (state)
                    ST_ADD:  ctrl.alu_ctl = ALU_ADD;
                    ST_AND:  ctrl.alu_ctl = ALU_AND;
                    ST_SUB:  ctrl.alu_ctl = ALU_SUB;
                    default: ctrl.alu_ctl = ALU_SLT;
                endcase
            end
            ST_SLL, ST_SRA:
            begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_SHIFT;
                ctrl.shamt_sel = SHAMT_FROM_INSTR;
                ctrl.alu_ctl   = (state == ST_SLL) ? ALU_SLL : ALU_SRA;
            end
            ST_DIV:  ctrl.alu_ctl = ALU_DIV; // Result goes to HI/LO inside the ALU
            ST_MULT: ctrl.alu_ctl = ALU_MULT;
            ST_JR:
            begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_REG;
            end
            ST_ADDI, ST_LUI:
            begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = (state == ST_ADDI) ? WB_ALU : WB_SHIFT;
                ctrl.alu_ctl   = (state == ST_ADDI) ? ALU_ADD : ALU_LUI;
            end
            ST_BEQ, ST_BNE:
            begin
                ctrl.branch    = 1'b1;
                ctrl.alu_ctl   = ALU_SUB; // Compare by subtraction
                ctrl.pc_source = PC_SRC_BRANCH;
                ctrl.pc_write  = (state == ST_BEQ) ? zero_flag : ~zero_flag;
            end
            ST_LW:
            begin
                case (step)
                    2'd0:
                    begin
                        ctrl.alu_src = 1'b1; // Base plus offset
                        ctrl.alu_ctl = ALU_ADD;
                    end
                    2'd1:
                        ctrl.mem_read = 1'b1;
                    default:
                    begin
                        ctrl.reg_write = 1'b1;
                        ctrl.wb_sel    = WB_MEM;
                    end
                endcase
            end
            ST_SW:
            begin
                if (step == 2'd0)
                begin
                    ctrl.alu_src = 1'b1;
                    ctrl.alu_ctl = ALU_ADD;
                end
                else
                begin
                    ctrl.mem_write = 1'b1;
                end
            end
            ST_J, ST_JAL:
            begin
                ctrl.jump      = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_JUMP;
                ctrl.reg_write = (state == ST_JAL); // Link into $ra
            end
            ST_OVERFLOW, ST_ILLEGAL, ST_DIV0:
            begin
                ctrl.epc_load  = 1'b1; // Save faulting PC
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_JUMP;
            end
            default:
                ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cu_pkg.sv
`default_nettype none

package cu_pkg;

    typedef logic [31:0] instr_word_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] jaddr_t;
    typedef logic [3:0]  alu_ctl_t;
    typedef logic [2:0]  wb_sel_t;
    typedef logic [1:0]  pc_src_t;
    typedef logic [1:0]  shamt_sel_t;
    typedef logic [1:0]  step_t;

    localparam opcode_t OP_TYPE_R = 6'b000000;
    localparam opcode_t OP_ADDI   = 6'b001000;
    localparam opcode_t OP_BEQ    = 6'b000100;
    localparam opcode_t OP_BNE    = 6'b000101;
    localparam opcode_t OP_LUI    = 6'b001111;
    localparam opcode_t OP_LW     = 6'b100011;
    localparam opcode_t OP_SW     = 6'b101011;
    localparam opcode_t OP_J      = 6'b000010;
    localparam opcode_t OP_JAL    = 6'b000011;

    localparam funct_t FUNCT_ADD  = 6'b100000;
    localparam funct_t FUNCT_AND  = 6'b100100;
    localparam funct_t FUNCT_DIV  = 6'b011010;
    localparam funct_t FUNCT_MULT = 6'b011000;
    localparam funct_t FUNCT_JR   = 6'b001000;
    localparam funct_t FUNCT_SLL  = 6'b000000;
    localparam funct_t FUNCT_SLT  = 6'b101010;
    localparam funct_t FUNCT_SRA  = 6'b000011;
    localparam funct_t FUNCT_SUB  = 6'b100010;

    localparam alu_ctl_t ALU_AND  = 4'd1;
    localparam alu_ctl_t ALU_ADD  = 4'd2;
    localparam alu_ctl_t ALU_SLL  = 4'd4;
    localparam alu_ctl_t ALU_SRA  = 4'd5;
    localparam alu_ctl_t ALU_SUB  = 4'd6;
    localparam alu_ctl_t ALU_SLT  = 4'd7;
    localparam alu_ctl_t ALU_LUI  = 4'd8;
    localparam alu_ctl_t ALU_DIV  = 4'd9;
    localparam alu_ctl_t ALU_MULT = 4'd10;

    localparam wb_sel_t WB_ALU   = 3'd1; // ALU result
    localparam wb_sel_t WB_MEM   = 3'd3; // Memory data register
    localparam wb_sel_t WB_SHIFT = 3'd6; // Shifter output

    localparam pc_src_t PC_SRC_INC    = 2'd0; // PC + 4
    localparam pc_src_t PC_SRC_BRANCH = 2'd1;
    localparam pc_src_t PC_SRC_REG    = 2'd2;
    localparam pc_src_t PC_SRC_JUMP   = 2'd3; // Also the exception vector

    localparam shamt_sel_t SHAMT_FROM_INSTR = 2'd3;

    // Cycles spent in the multi-cycle states
    localparam int FETCH_STEPS = 2;
    localparam int LW_STEPS    = 3;
    localparam int SW_STEPS    = 2;

    typedef enum logic [4:0] {
        IC_ADD, IC_AND, IC_SUB, IC_SLT, IC_SLL, IC_SRA,
        IC_DIV, IC_MULT, IC_JR, IC_ADDI, IC_BEQ, IC_BNE,
        IC_LUI, IC_LW, IC_SW, IC_J, IC_JAL, IC_ILLEGAL
    } instr_class_t;

    // Sparse encoding with unused codes left as gaps
    typedef enum logic [4:0] {
        ST_RESET    = 5'b00000,
        ST_FETCH    = 5'b00001,
        ST_DECODE   = 5'b00010,
        ST_ADD      = 5'b00011,
        ST_AND      = 5'b00100,
        ST_DIV      = 5'b00101,
        ST_MULT     = 5'b00110,
        ST_JR       = 5'b00111,
        ST_SLL      = 5'b01010,
        ST_SLT      = 5'b01011,
        ST_SRA      = 5'b01100,
        ST_SUB      = 5'b01101,
        ST_ADDI     = 5'b01111,
        ST_BEQ      = 5'b10000,
        ST_BNE      = 5'b10001,
        ST_LUI      = 5'b10100,
        ST_LW       = 5'b10101,
        ST_SW       = 5'b10111,
        ST_J        = 5'b11000,
        ST_JAL      = 5'b11001,
        ST_OVERFLOW = 5'b11010,
        ST_ILLEGAL  = 5'b11011,
        ST_DIV0     = 5'b11100
    } cu_state_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        shamt_t   shamt;
        funct_t   funct;
        imm_t     immediate;
        jaddr_t   address;
    } instr_fields_t;

    typedef struct packed {
        logic       reg_dst;
        logic       jump;
        logic       branch;
        logic       mem_read;
        logic       mem_write;
        logic       alu_src;
        logic       reg_write;
        logic       pc_write;
        logic       epc_load;
        wb_sel_t    wb_sel;
        alu_ctl_t   alu_ctl;
        pc_src_t    pc_source;
        shamt_sel_t shamt_sel;
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: hw/cu_sequencer.sv
`default_nettype none

module cu_sequencer (
    input  wire                       clk,
    input  wire                       reset,
    input  wire cu_pkg::instr_class_t iclass,
    input  wire                       overflow,
    input  wire                       div_zero,
    output cu_pkg::cu_state_t         state,
    output cu_pkg::step_t             step
);
    import cu_pkg::*;

    cu_state_t next_state;
    step_t     last_step;
    logic      at_last;

    // Execution state chosen by the decoder class
    function automatic cu_state_t decode_target(input instr_class_t ic);
        case (ic)
            IC_ADD:  return ST_ADD;
            IC_AND:  return ST_AND;
            IC_SUB:  return ST_SUB;
            IC_SLT:  return ST_SLT;
            IC_SLL:  return ST_SLL;
            IC_SRA:  return ST_SRA;
            IC_DIV:  return ST_DIV;
            IC_MULT: return ST_MULT;
            IC_JR:   return ST_JR;
            IC_ADDI: return ST_ADDI;
            IC_BEQ:  return ST_BEQ;
            IC_BNE:  return ST_BNE;
            IC_LUI:  return ST_LUI;
            IC_LW:   return ST_LW;
            IC_SW:   return ST_SW;
            IC_J:    return ST_J;
            IC_JAL:  return ST_JAL;
            default: return ST_ILLEGAL;
        endcase
    endfunction

    // Final step index of the current state
    always_comb
    begin
        case (state)
            ST_FETCH: last_step = step_t'(FETCH_STEPS - 1);
            ST_LW:    last_step = step_t'(LW_STEPS - 1);
            ST_SW:    last_step = step_t'(SW_STEPS - 1);
            default:  last_step = '0; // Single-cycle states
        endcase
    end

    assign at_last = (step == last_step);

    always_comb
    begin
        case (state)
            ST_RESET:
                next_state = ST_FETCH;
            ST_FETCH:
                next_state = ST_DECODE;
            ST_DECODE:
                next_state = decode_target(iclass);
            ST_ADD, ST_SUB, ST_ADDI:
            begin
                // Flag is valid at the closing edge of the ALU cycle
                if (overflow)
                    next_state = ST_OVERFLOW;
                else
                    next_state = ST_FETCH;
            end
            ST_DIV:
            begin
                if (div_zero)
                    next_state = ST_DIV0;
                else
                    next_state = ST_FETCH;
            end
            default:
                next_state = ST_FETCH; // Other instructions and exception states
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_RESET;
            step  <= '0;
        end
        else if (at_last)
        begin
            state <= next_state;
            step  <= '0;
        end
        else
        begin
            step <= step + step_t'(1); // Advance inside the current state
        end
    end

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  wire cu_pkg::instr_word_t instruction,
    output cu_pkg::instr_fields_t    fields,
    output cu_pkg::instr_class_t     iclass
);
    import cu_pkg::*;

    // Fixed slices that overlap where the formats do
    always_comb
    begin
        fields.opcode    = instruction[31:26];
        fields.rs        = instruction[25:21];
        fields.rt        = instruction[20:16];
        fields.rd        = instruction[15:11];
        fields.shamt     = instruction[10:6];
        fields.funct     = instruction[5:0];
        fields.immediate = instruction[15:0];
        fields.address   = instruction[25:0];
    end

    always_comb
    begin
        iclass = IC_ILLEGAL;
        case (fields.opcode)
            OP_TYPE_R:
            begin
                // Funct picks the R-type operation
                case (fields.funct)
                    FUNCT_ADD:  iclass = IC_ADD;
                    FUNCT_AND:  iclass = IC_AND;
                    FUNCT_SUB:  iclass = IC_SUB;
                    FUNCT_SLT:  iclass = IC_SLT;
                    FUNCT_SLL:  iclass = IC_SLL;
                    FUNCT_SRA:  iclass = IC_SRA;
                    FUNCT_DIV:  iclass = IC_DIV;
                    FUNCT_MULT: iclass = IC_MULT;
                    FUNCT_JR:   iclass = IC_JR;
                    default:    iclass = IC_ILLEGAL; // MFHI, MFLO, XCHG land here
                endcase
            end
            OP_ADDI: iclass = IC_ADDI;
            OP_BEQ:  iclass = IC_BEQ;
            OP_BNE:  iclass = IC_BNE;
            OP_LUI:  iclass = IC_LUI;
            OP_LW:   iclass = IC_LW;
            OP_SW:   iclass = IC_SW;
            OP_J:    iclass = IC_J;
            OP_JAL:  iclass = IC_JAL;
            default: iclass = IC_ILLEGAL; // Includes LB, SB, SLLM
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_control_unit -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "Run passed"
else
    echo "Run failed, see sim.log"
    exit 1
fi

// File: tests/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic ctrl_word_t cw(input logic [8:0] bits, input wb_sel_t wb,
                                  input alu_ctl_t alu, input pc_src_t pcs,
                                  input shamt_sel_t shs);
    return {bits, wb, alu, pcs, shs};
endfunction

function automatic instr_word_t build_r(input funct_t funct, input shamt_t shamt);
    return {OP_TYPE_R, 5'd9, 5'd10, 5'd11, shamt, funct};
endfunction

function automatic instr_word_t build_i(input opcode_t op, input imm_t imm);
    return {op, 5'd4, 5'd5, imm};
endfunction

function automatic instr_word_t build_j(input opcode_t op, input jaddr_t addr);
    return {op, addr};
endfunction

// Starts and ends at the falling edge inside the first fetch cycle
task automatic run_instr(input instr_word_t instr, input logic zf, input logic ov,
                         input logic dz, input cu_state_t exec_state, input int nsteps,
                         input ctrl_word_t w0, input ctrl_word_t w1, input ctrl_word_t w2,
                         input cu_state_t after_state);
    ctrl_word_t words [3];
    ctrl_word_t after_word;
    words[0] = w0;
    words[1] = w1;
    words[2] = w2;
    after_word = (after_state == ST_FETCH) ? FETCH_W : EXC_W;
    check_value("current_state", 32'(current_state), 32'(ST_FETCH));
    check_value("ctrl", 32'(ctrl), 32'(FETCH_W));
    instruction = instr;
    zero_flag   = zf;
    overflow    = ov;
    div_zero    = dz;
    @(negedge clk);
    check_value("current_state", 32'(current_state), 32'(ST_FETCH));
    check_value("ctrl", 32'(ctrl), 32'(FETCH_W));
    @(negedge clk);
    check_value("current_state", 32'(current_state), 32'(ST_DECODE));
    check_value("ctrl", 32'(ctrl), 32'(0));
    for (int i = 0; i < nsteps; i++)
    begin
        @(negedge clk);
        check_value("current_state", 32'(current_state), 32'(exec_state));
        check_value("ctrl", 32'(ctrl), 32'(words[i]));
    end
    @(negedge clk);
    check_value("current_state", 32'(current_state), 32'(after_state));
    check_value("ctrl", 32'(ctrl), 32'(after_word));
    if (after_state != ST_FETCH)
    begin
        @(negedge clk); // Exception state hands back to fetch
        check_value("current_state", 32'(current_state), 32'(ST_FETCH));
    end
endtask

task automatic test_reset_fetch();
    repeat (4)
    begin
        @(negedge clk);
        check_value("current_state", 32'(current_state), 32'(ST_RESET));
        check_value("ctrl", 32'(ctrl), 32'(0));
    end
    reset = 1'b0;
    @(negedge clk);
    run_instr(build_r(FUNCT_ADD, 5'd0), 0, 0, 0, ST_ADD, 1,
              cw(9'b100000100, WB_ALU, ALU_ADD, 0, 0), '0, '0, ST_FETCH);
endtask

task automatic test_single_cycle();
    ctrl_word_t z;
    z = '0;
    run_instr(build_r(FUNCT_AND, 0), 0, 0, 0, ST_AND, 1,
              cw(9'b100000100, WB_ALU, ALU_AND, 0, 0), z, z, ST_FETCH);
    run_instr(build_r(FUNCT_SUB, 0), 0, 0, 0, ST_SUB, 1,
              cw(9'b100000100, WB_ALU, ALU_SUB, 0, 0), z, z, ST_FETCH);
    run_instr(build_r(FUNCT_SLT, 0), 0, 0, 0, ST_SLT, 1,
              cw(9'b100000100, WB_ALU, ALU_SLT, 0, 0), z, z, ST_FETCH);
    run_instr(build_r(FUNCT_SLL, 5'd3), 0, 0, 0, ST_SLL, 1,
              cw(9'b100000100, WB_SHIFT, ALU_SLL, 0, SHAMT_FROM_INSTR), z, z, ST_FETCH);
    run_instr(build_r(FUNCT_SRA, 5'd7), 0, 0, 0, ST_SRA, 1,
              cw(9'b100000100, WB_SHIFT, ALU_SRA, 0, SHAMT_FROM_INSTR), z, z, ST_FETCH);
    run_instr(build_r(FUNCT_DIV, 0), 0, 0, 0, ST_DIV, 1, cw(0, 0, ALU_DIV, 0, 0), z, z,
              ST_FETCH);
    run_instr(build_r(FUNCT_MULT, 0), 0, 0, 0, ST_MULT, 1, cw(0, 0, ALU_MULT, 0, 0), z, z,
              ST_FETCH);
    run_instr(build_i(OP_ADDI, 16'h0010), 0, 0, 0, ST_ADDI, 1,
              cw(9'b000001100, WB_ALU, ALU_ADD, 0, 0), z, z, ST_FETCH);
    run_instr(build_i(OP_LUI, 16'hbeef), 0, 0, 0, ST_LUI, 1,
              cw(9'b000001100, WB_SHIFT, ALU_LUI, 0, 0), z, z, ST_FETCH);
endtask

task automatic test_mem_access();
    run_instr(build_i(OP_LW, 16'h0040), 0, 0, 0, ST_LW, 3,
              cw(9'b000001000, 0, ALU_ADD, 0, 0), cw(9'b000100000, 0, 0, 0, 0),
              cw(9'b000000100, WB_MEM, 0, 0, 0), ST_FETCH);
    run_instr(build_i(OP_SW, 16'h0044), 0, 0, 0, ST_SW, 2,
              cw(9'b000001000, 0, ALU_ADD, 0, 0), cw(9'b000010000, 0, 0, 0, 0), '0, ST_FETCH);
endtask

task automatic test_branch_jump();
    for (int z = 0; z < 2; z++)
    begin
        run_instr(build_i(OP_BEQ, 16'hfffc), z[0], 0, 0, ST_BEQ, 1,
                  cw({7'b0010000, z[0], 1'b0}, 0, ALU_SUB, PC_SRC_BRANCH, 0), '0, '0, ST_FETCH);
        run_instr(build_i(OP_BNE, 16'h0008), z[0], 0, 0, ST_BNE, 1,
                  cw({7'b0010000, ~z[0], 1'b0}, 0, ALU_SUB, PC_SRC_BRANCH, 0), '0, '0, ST_FETCH);
    end
    run_instr(build_j(OP_J, 26'h0123456), 0, 0, 0, ST_J, 1,
              cw(9'b010000010, 0, 0, PC_SRC_JUMP, 0), '0, '0, ST_FETCH);
    run_instr(build_j(OP_JAL, 26'h2abcdef), 0, 0, 0, ST_JAL, 1,
              cw(9'b010000110, 0, 0, PC_SRC_JUMP, 0), '0, '0, ST_FETCH);
    run_instr(build_r(FUNCT_JR, 0), 0, 0, 0, ST_JR, 1,
              cw(9'b000000010, 0, 0, PC_SRC_REG, 0), '0, '0, ST_FETCH);
endtask

task automatic test_exceptions();
    run_instr(build_r(FUNCT_ADD, 0), 0, 1, 0, ST_ADD, 1,
              cw(9'b100000100, WB_ALU, ALU_ADD, 0, 0), '0, '0, ST_OVERFLOW);
    run_instr(build_r(FUNCT_SUB, 0), 0, 1, 0, ST_SUB, 1,
              cw(9'b100000100, WB_ALU, ALU_SUB, 0, 0), '0, '0, ST_OVERFLOW);
    run_instr(build_i(OP_ADDI, 16'h7fff), 0, 1, 0, ST_ADDI, 1,
              cw(9'b000001100, WB_ALU, ALU_ADD, 0, 0), '0, '0, ST_OVERFLOW);
    run_instr(build_r(FUNCT_DIV, 0), 0, 0, 1, ST_DIV, 1, cw(0, 0, ALU_DIV, 0, 0), '0, '0,
              ST_DIV0);
    // AND ignores the overflow flag
    run_instr(build_r(FUNCT_AND, 0), 0, 1, 0, ST_AND, 1,
              cw(9'b100000100, WB_ALU, ALU_AND, 0, 0), '0, '0, ST_FETCH);
    run_instr(build_i(6'b100000, 16'h0000), 0, 0, 0, ST_ILLEGAL, 1, EXC_W, '0, '0, ST_FETCH);
    run_instr(build_r(6'b010000, 0), 0, 0, 0, ST_ILLEGAL, 1, EXC_W, '0, '0, ST_FETCH); // MFHI
endtask

task automatic test_fields();
    instr_word_t w;
    overflow = 1'b0;
    div_zero = 1'b0;
    repeat (FIELD_TESTS)
    begin
        @(negedge clk);
        w = $urandom();
        instruction = w;
        @(posedge clk);
        check_value("fields.opcode", 32'(fields.opcode), 32'(w[31:26]));
        check_value("fields.rs", 32'(fields.rs), 32'(w[25:21]));
        check_value("fields.rt", 32'(fields.rt), 32'(w[20:16]));
        check_value("fields.rd", 32'(fields.rd), 32'(w[15:11]));
        check_value("fields.shamt", 32'(fields.shamt), 32'(w[10:6]));
        check_value("fields.funct", 32'(fields.funct), 32'(w[5:0]));
        check_value("fields.immediate", 32'(fields.immediate), 32'(w[15:0]));
        check_value("fields.address", 32'(fields.address), 32'(w[25:0]));
    end
endtask

`endif

// File: tests/tb_control_unit.sv
`default_nettype none

module tb_control_unit;
    import cu_pkg::*;

    localparam int FIELD_TESTS    = 24;
    localparam int RUN_CALLS      = 26;
    localparam int MAX_RUN_CYCLES = 6; // Fetch, decode and the three LW steps
    localparam int TEST_CYCLES    = 6 + RUN_CALLS * MAX_RUN_CYCLES + FIELD_TESTS;
    localparam int TIMEOUT        = TEST_CYCLES * 10 + 500;

    // Flag bits in order reg_dst jump branch mem_read mem_write alu_src reg_write pc_write epc_load
    localparam ctrl_word_t FETCH_W = {9'b000100010, 3'd0, 4'd0, PC_SRC_INC, 2'd0};
    localparam ctrl_word_t EXC_W   = {9'b000000011, 3'd0, 4'd0, PC_SRC_JUMP, 2'd0};

    logic          clk = 1'b0;
    logic          reset;
    instr_word_t   instruction;
    logic          zero_flag;
    logic          overflow;
    logic          div_zero;
    instr_fields_t fields;
    ctrl_word_t    ctrl;
    cu_state_t     current_state;

    int            errors = 0;
    int            checks = 0;

    control_unit dut_i (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .zero_flag     (zero_flag),
        .overflow      (overflow),
        .div_zero      (div_zero),
        .fields        (fields),
        .ctrl          (ctrl),
        .current_state (current_state)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    `include "tb_tasks.svh"

    // Watchdog sized from the test cycle budget
    initial
    begin
        #(TIMEOUT);
        $display("Timeout after %0d time units, the tests did not finish", TIMEOUT);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        instruction = '0;
        zero_flag   = 1'b0;
        overflow    = 1'b0;
        div_zero    = 1'b0;
        reset       = 1'b1;
        void'($urandom(32'haa5b_2c31));
        test_reset_fetch();
        test_single_cycle();
        test_mem_access();
        test_branch_jump();
        test_exceptions();
        test_fields(); // Random words leave the FSM in any state
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
